// File: logic/video_defines.svh
// LCD scan timing in LCD clocks and lines
// Frame buffer depth and bring-up startup delay

`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal timing, counted in LCD clocks
`define H_BACK_PORCH 216
`define H_ACTIVE 640
`define H_TOTAL 1056

// Vertical timing, counted in lines
`define V_BACK_PORCH 35
`define V_ACTIVE 480
`define V_TOTAL 525

// Word pairs held by the frame buffer
`define FIFO_DEPTH 1024

// Cycles spent in each bring-up wait state
`define STARTUP_DELAY 256

`endif

// File: logic/pixel_pkg.sv
// Pixel component types for camera and LCD
// Stored half-pixel word and frame counter types

`default_nettype none

package pixel_pkg;

	// Camera colour component
	typedef logic [9:0] cam_pix_t;

	// LCD colour component
	typedef logic [7:0] lcd_pix_t;

	// One buffer word, half of a packed pixel
	typedef logic [15:0] buf_word_t;

	typedef logic [31:0] frame_count_t;

endpackage

`default_nettype wire

// File: logic/control_pkg.sv
// LCD counter and startup delay types
// Bring-up state encoding

`default_nettype none

package control_pkg;

	typedef logic [10:0] hcount_t;
	typedef logic [9:0] vcount_t;

	// Wide enough for the long hardware delay
	typedef logic [19:0] delay_count_t;

	typedef enum logic [2:0] {
		BUF_START,
		WAIT_BUF,
		WAIT_CAM,
		RUN,
		RELOAD_WAIT
	} bring_up_state_t;

endpackage

`default_nettype wire

// File: logic/camera_packer.sv
// Camera pixel packer
// Splits each RGB pixel into two buffer words and counts frames

`timescale 1ns/100ps
`default_nettype none

module camera_packer
	import pixel_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic enable,
	input logic cam_valid,
	input logic cam_frame_start,
	input cam_pix_t cam_red,
	input cam_pix_t cam_green,
	input cam_pix_t cam_blue,
	output logic wr_strobe,
	output buf_word_t wr_word1,
	output buf_word_t wr_word2,
	output frame_count_t frame_count
);

logic take_pixel;

assign take_pixel = enable && cam_valid;

always_ff @(posedge Clock or negedge Resetn) begin
	if (~Resetn) begin
		wr_strobe <= 1'b0;
		frame_count <= '0;
	end else begin
		wr_strobe <= take_pixel;
		if (enable && cam_frame_start)
			frame_count <= frame_count + 1'b1;
	end
end

// Green is split across the two words
always_ff @(posedge Clock) begin
	if (take_pixel) begin
		wr_word1 <= {1'b0, cam_green[9:5], cam_blue};
		wr_word2 <= {1'b0, cam_green[4:0], cam_red};
	end
end

endmodule

`default_nettype wire

// File: logic/frame_fifo.sv
// Frame buffer FIFO of packed word pairs
// Flush input, sticky overflow and underflow flags

`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module frame_fifo
	import pixel_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic flush,
	input logic wr_strobe,
	input buf_word_t wr_word1,
	input buf_word_t wr_word2,
	input logic rd_strobe,
	output buf_word_t rd_word1,
	output buf_word_t rd_word2,
	output logic overflow,
	output logic underflow
);

localparam int unsigned DEPTH = `FIFO_DEPTH;
localparam int unsigned ADDR_W = $clog2(DEPTH);
localparam logic [ADDR_W:0] FULL_COUNT = DEPTH[ADDR_W:0];

buf_word_t mem_word1 [DEPTH];
buf_word_t mem_word2 [DEPTH];

logic [ADDR_W-1:0] wr_ptr;
logic [ADDR_W-1:0] rd_ptr;
logic [ADDR_W:0] count;
logic full;
logic empty;
logic wr_ok;
logic rd_ok;

assign full = (count == FULL_COUNT);
assign empty = (count == '0);
assign wr_ok = wr_strobe && !full && !flush;
assign rd_ok = rd_strobe && !empty && !flush;

always_ff @(posedge Clock) begin
	if (wr_ok) begin
		mem_word1[wr_ptr] <= wr_word1;
		mem_word2[wr_ptr] <= wr_word2;
	end
end

// Empty reads give a black pixel
always_ff @(posedge Clock) begin
	if (rd_ok) begin
		rd_word1 <= mem_word1[rd_ptr];
		rd_word2 <= mem_word2[rd_ptr];
	end else if (rd_strobe) begin
		rd_word1 <= '0;
		rd_word2 <= '0;
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (~Resetn) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		overflow <= 1'b0;
		underflow <= 1'b0;
	end else if (flush) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		overflow <= 1'b0;
		underflow <= 1'b0;
	end else begin
		if (wr_ok)
			wr_ptr <= wr_ptr + 1'b1;
		if (rd_ok)
			rd_ptr <= rd_ptr + 1'b1;
		count <= count + {{ADDR_W{1'b0}}, wr_ok} - {{ADDR_W{1'b0}}, rd_ok};
		if (wr_strobe && full)
			overflow <= 1'b1;
		if (rd_strobe && empty)
			underflow <= 1'b1;
	end
end

assert property (@(posedge Clock) disable iff (~Resetn) count <= FULL_COUNT);

// A read on an empty buffer is never served from memory
assert property (
	@(posedge Clock) disable iff (~Resetn)
	(rd_strobe && empty && !flush) |=> (rd_word1 == '0 && rd_word2 == '0 && underflow)
);

endmodule

`default_nettype wire

// File: logic/lcd_scanout.sv
// LCD scan-out with H and V counters, syncs and data enable
// Reads one word pair per active pixel and unpacks it to 8-bit RGB

`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module lcd_scanout
	import pixel_pkg::*;
	import control_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic enable,
	input buf_word_t rd_word1,
	input buf_word_t rd_word2,
	output logic rd_strobe,
	output logic lcd_nclk,
	output logic lcd_hd,
	output logic lcd_vd,
	output logic lcd_den,
	output lcd_pix_t lcd_r,
	output lcd_pix_t lcd_g,
	output lcd_pix_t lcd_b
);

localparam hcount_t H_FIRST = hcount_t'(`H_BACK_PORCH);
localparam hcount_t H_LAST = hcount_t'(`H_BACK_PORCH + `H_ACTIVE - 1);
localparam hcount_t H_END = hcount_t'(`H_TOTAL - 1);
localparam vcount_t V_FIRST = vcount_t'(`V_BACK_PORCH);
localparam vcount_t V_LAST = vcount_t'(`V_BACK_PORCH + `V_ACTIVE - 1);
localparam vcount_t V_END = vcount_t'(`V_TOTAL - 1);

logic clk_en;
hcount_t h_count;
vcount_t v_count;
logic in_window;

assign in_window = (h_count >= H_FIRST) && (h_count <= H_LAST) &&
	(v_count >= V_FIRST) && (v_count <= V_LAST);

// Read in the low phase, so the word is back before the output update
assign rd_strobe = enable && !clk_en && in_window;

// LCD samples on the rising edge, mid-way through each pixel
assign lcd_nclk = clk_en;

always_ff @(posedge Clock or negedge Resetn) begin
	if (~Resetn) begin
		clk_en <= 1'b0;
		h_count <= '0;
		v_count <= '0;
	end else if (!enable) begin
		clk_en <= 1'b0;
		h_count <= '0;
		v_count <= '0;
	end else begin
		clk_en <= !clk_en;
		if (clk_en) begin
			if (h_count == H_END) begin
				h_count <= '0;
				if (v_count == V_END)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end
end

// Outputs change together once per LCD clock
always_ff @(posedge Clock or negedge Resetn) begin
	if (~Resetn) begin
		lcd_hd <= 1'b0;
		lcd_vd <= 1'b0;
		lcd_den <= 1'b0;
		lcd_r <= '0;
		lcd_g <= '0;
		lcd_b <= '0;
	end else if (!enable) begin
		lcd_hd <= 1'b0;
		lcd_vd <= 1'b0;
		lcd_den <= 1'b0;
		lcd_r <= '0;
		lcd_g <= '0;
		lcd_b <= '0;
	end else if (clk_en) begin
		// Syncs are active low at count zero
		lcd_hd <= (h_count != '0);
		lcd_vd <= (v_count != '0);
		lcd_den <= in_window;
		if (in_window) begin
			lcd_r <= rd_word2[9:2];
			lcd_g <= {rd_word1[14:10], rd_word2[14:12]};
			lcd_b <= rd_word1[9:2];
		end else begin
			lcd_r <= '0;
			lcd_g <= '0;
			lcd_b <= '0;
		end
	end
end

// Each read lands on a displayed pixel two cycles later
assert property (
	@(posedge Clock) disable iff (~Resetn || !enable)
	rd_strobe |-> ##1 clk_en ##1 lcd_den
);

endmodule

`default_nettype wire

// File: logic/bring_up_sequencer.sv
// Bring-up sequencer for buffer, camera and LCD
// Startup delays and reload handling

`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module bring_up_sequencer
	import control_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic reload,
	output logic cam_enable,
	output logic lcd_enable,
	output logic buf_flush
);

localparam delay_count_t DELAY_LAST = delay_count_t'(`STARTUP_DELAY - 1);

bring_up_state_t state;
delay_count_t start_delay;

// Buffer is held empty while starting or reloading
assign buf_flush = (state == BUF_START) || (state == RELOAD_WAIT);

always_ff @(posedge Clock or negedge Resetn) begin
	if (~Resetn) begin
		state <= BUF_START;
		cam_enable <= 1'b0;
		lcd_enable <= 1'b0;
		start_delay <= '0;
	end else begin
		case (state)
			BUF_START: begin
				start_delay <= '0;
				state <= WAIT_BUF;
			end
			WAIT_BUF: begin
				if (start_delay == DELAY_LAST) begin
					cam_enable <= 1'b1;
					start_delay <= '0;
					state <= WAIT_CAM;
				end else begin
					start_delay <= start_delay + 1'b1;
				end
			end
			// Camera settles before the LCD starts reading
			WAIT_CAM: begin
				if (start_delay == DELAY_LAST) begin
					lcd_enable <= 1'b1;
					state <= RUN;
				end else begin
					start_delay <= start_delay + 1'b1;
				end
			end
			RUN: begin
				if (reload) begin
					cam_enable <= 1'b0;
					lcd_enable <= 1'b0;
					start_delay <= '0;
					state <= RELOAD_WAIT;
				end
			end
			RELOAD_WAIT: begin
				if (start_delay == DELAY_LAST) begin
					if (!reload)
						state <= BUF_START;
				end else begin
					start_delay <= start_delay + 1'b1;
				end
			end
			default: state <= BUF_START;
		endcase
	end
end

endmodule

`default_nettype wire

// File: logic/camera_lcd_top.sv
// Camera to LCD video path top level
// Sequencer, packer, frame FIFO and LCD scan-out

`timescale 1ns/100ps
`default_nettype none

module camera_lcd_top
	import pixel_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic cam_valid,
	input logic cam_frame_start,
	input cam_pix_t cam_red,
	input cam_pix_t cam_green,
	input cam_pix_t cam_blue,
	input logic reload,
	output logic lcd_nclk,
	output logic lcd_hd,
	output logic lcd_vd,
	output logic lcd_den,
	output lcd_pix_t lcd_r,
	output lcd_pix_t lcd_g,
	output lcd_pix_t lcd_b,
	output frame_count_t frame_count,
	output logic overflow,
	output logic underflow
);

logic cam_enable;
logic lcd_enable;
logic buf_flush;
logic wr_strobe;
logic rd_strobe;
buf_word_t wr_word1;
buf_word_t wr_word2;
buf_word_t rd_word1;
buf_word_t rd_word2;

bring_up_sequencer sequencer_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.reload(reload),
	.cam_enable(cam_enable),
	.lcd_enable(lcd_enable),
	.buf_flush(buf_flush)
);

camera_packer packer_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.enable(cam_enable),
	.cam_valid(cam_valid),
	.cam_frame_start(cam_frame_start),
	.cam_red(cam_red),
	.cam_green(cam_green),
	.cam_blue(cam_blue),
	.wr_strobe(wr_strobe),
	.wr_word1(wr_word1),
	.wr_word2(wr_word2),
	.frame_count(frame_count)
);

frame_fifo fifo_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.flush(buf_flush),
	.wr_strobe(wr_strobe),
	.wr_word1(wr_word1),
	.wr_word2(wr_word2),
	.rd_strobe(rd_strobe),
	.rd_word1(rd_word1),
	.rd_word2(rd_word2),
	.overflow(overflow),
	.underflow(underflow)
);

lcd_scanout scanout_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.enable(lcd_enable),
	.rd_word1(rd_word1),
	.rd_word2(rd_word2),
	.rd_strobe(rd_strobe),
	.lcd_nclk(lcd_nclk),
	.lcd_hd(lcd_hd),
	.lcd_vd(lcd_vd),
	.lcd_den(lcd_den),
	.lcd_r(lcd_r),
	.lcd_g(lcd_g),
	.lcd_b(lcd_b)
);

endmodule

`default_nettype wire

// File: tb/lcd_checker.sv
// LCD output checker
// Compares displayed pixels with a queue of expected pixels
// Also checks idle outputs after reset, blanking colours, sync and data enable
// timing, and the frame count

`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module lcd_checker
	import pixel_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic [2:0] test_num,
	input logic idle_check,
	input logic exp_push,
	input lcd_pix_t exp_r,
	input lcd_pix_t exp_g,
	input lcd_pix_t exp_b,
	input logic frame_check,
	input frame_count_t exp_frames,
	input logic lcd_nclk,
	input logic lcd_hd,
	input logic lcd_vd,
	input logic lcd_den,
	input lcd_pix_t lcd_r,
	input lcd_pix_t lcd_g,
	input lcd_pix_t lcd_b,
	input frame_count_t frame_count,
	input logic overflow,
	input logic underflow,
	output int pixels_shown,
	output int black_shown,
	output int pixel_errors,
	output int timing_errors,
	output int idle_errors,
	output int frame_errors
);

// Expected pixels as {r, g, b}, oldest first
logic [23:0] expected_q [$];

// Panel position in LCD clocks and lines since the syncs
int h_pos;
int v_pos;

function automatic string test_name(input logic [2:0] num);
	case (num)
		3'd1: return "reset_idle";
		3'd2: return "first_frame";
		3'd4: return "underflow";
		3'd5: return "reload_overflow";
		3'd6: return "frame_count";
		default: return "scan";
	endcase
endfunction

// Active area starts after the back porch of each sync
function automatic bit in_active_area(input int h, input int v);
	return h >= `H_BACK_PORCH && h < `H_BACK_PORCH + `H_ACTIVE &&
		v >= `V_BACK_PORCH && v < `V_BACK_PORCH + `V_ACTIVE;
endfunction

// DUT outputs move on the rising edge, so sample on the falling one
always @(negedge Clock) begin : sample
	logic [23:0] shown;
	logic [23:0] expected;
	logic den_exp;
	shown = {lcd_r, lcd_g, lcd_b};
	if (!Resetn) begin
		expected_q.delete();
		h_pos = 0;
		v_pos = 0;
		pixels_shown = 0;
		black_shown = 0;
		pixel_errors = 0;
		timing_errors = 0;
		idle_errors = 0;
		frame_errors = 0;
	end else begin
		if (exp_push)
			expected_q.push_back({exp_r, exp_g, exp_b});
		if (idle_check && (lcd_den || lcd_hd || lcd_vd || overflow || underflow)) begin
			idle_errors++;
			$display("reset_idle: LCD sync, data enable or a flag went active before start");
		end
		// Blanking must be black
		if (!lcd_den && shown != '0) begin
			timing_errors++;
			$display("error scan_timing: expected %h actual %h", 24'h0, shown);
		end
		// Syncs are low at position zero, data enable follows the porches
		if (lcd_nclk) begin
			if (!lcd_hd) begin
				h_pos = 0;
				if (!lcd_vd)
					v_pos = 0;
				else
					v_pos++;
			end else begin
				h_pos++;
			end
			den_exp = in_active_area(h_pos, v_pos);
			if (lcd_den != den_exp) begin
				timing_errors++;
				$display("error scan_timing: expected den %b actual %b", den_exp, lcd_den);
			end
		end
		// One sample per LCD clock, at its rising edge
		if (lcd_nclk && lcd_den) begin
			if (expected_q.size() > 0) begin
				expected = expected_q.pop_front();
				pixels_shown++;
			end else begin
				// Nothing left in the buffer
				expected = '0;
				black_shown++;
			end
			if (shown != expected) begin
				pixel_errors++;
				$display("error %s: expected %h actual %h", test_name(test_num),
					expected, shown);
			end
		end
		if (frame_check && frame_count != exp_frames) begin
			frame_errors++;
			$display("error frame_count: expected %0d actual %0d", exp_frames, frame_count);
		end
	end
end

endmodule

`default_nettype wire

// File: tb/tb_camera_lcd.sv
// Testbench for the camera to LCD video path
// Clock, reset, random camera pixels, reference colours and the test sequence

`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module tb_camera_lcd
	import pixel_pkg::*;
();

localparam int COND_SHOWN = 0;
localparam int COND_BLACK = 1;
localparam int COND_UNDERFLOW = 2;
localparam int COND_OVERFLOW = 3;
localparam int COND_CLEARED = 4;

logic Clock;
logic Resetn;
logic cam_valid;
logic cam_frame_start;
cam_pix_t cam_red;
cam_pix_t cam_green;
cam_pix_t cam_blue;
logic reload;
logic lcd_nclk;
logic lcd_hd;
logic lcd_vd;
logic lcd_den;
lcd_pix_t lcd_r;
lcd_pix_t lcd_g;
lcd_pix_t lcd_b;
frame_count_t frame_count;
logic overflow;
logic underflow;

logic [2:0] test_num;
logic idle_check;
logic exp_push;
lcd_pix_t exp_r;
lcd_pix_t exp_g;
lcd_pix_t exp_b;
logic frame_check;
frame_count_t exp_frames;
int pixels_shown;
int black_shown;
int pixel_errors;
int timing_errors;
int idle_errors;
int frame_errors;

integer seed;
int frames_sent;
int tests_run;
int tests_failed;
int total_errors;
bit timed_out;

camera_lcd_top camera_lcd_top_i (.*);

lcd_checker lcd_checker_i (.*);

initial begin
	Clock = 1'b0;
	forever #2 Clock = ~Clock;
end

// Each LCD component is the upper 8 bits of the camera component
function automatic logic [23:0] expected_lcd(input cam_pix_t red, input cam_pix_t green,
	input cam_pix_t blue);
	return {red[9:2], green[9:2], blue[9:2]};
endfunction

function automatic bit condition_met(input int which, input int target);
	case (which)
		COND_SHOWN: return pixels_shown >= target;
		COND_BLACK: return black_shown >= target;
		COND_UNDERFLOW: return underflow;
		COND_OVERFLOW: return overflow;
		default: return !overflow && !underflow && !lcd_den;
	endcase
endfunction

task automatic wait_for(input int which, input int target, input int limit, input string what);
	int cycles;
	cycles = 0;
	do begin
		@(posedge Clock);
		cycles++;
	end while (!condition_met(which, target) && cycles < limit);
	if (!condition_met(which, target)) begin
		$display("timeout after %0d cycles waiting for %s", limit, what);
		timed_out = 1'b1;
	end
endtask

task automatic pulse_frame_start(input bit counted);
	@(posedge Clock);
	cam_frame_start <= 1'b1;
	@(posedge Clock);
	cam_frame_start <= 1'b0;
	if (counted)
		frames_sent++;
endtask

// Random pixels with random idle cycles, the first expect_n go to the checker
task automatic send_pixels(input int total, input int expect_n);
	int sent;
	int gap;
	cam_pix_t r;
	cam_pix_t g;
	cam_pix_t b;
	sent = 0;
	while (sent < total) begin
		@(posedge Clock);
		gap = $random(seed) & 3;
		if (gap == 0) begin
			cam_valid <= 1'b0;
			exp_push <= 1'b0;
		end else begin
			r = cam_pix_t'($random(seed));
			g = cam_pix_t'($random(seed));
			b = cam_pix_t'($random(seed));
			cam_valid <= 1'b1;
			cam_red <= r;
			cam_green <= g;
			cam_blue <= b;
			exp_push <= (sent < expect_n);
			{exp_r, exp_g, exp_b} <= expected_lcd(r, g, b);
			sent++;
		end
	end
	@(posedge Clock);
	cam_valid <= 1'b0;
	exp_push <= 1'b0;
endtask

task automatic report_test(input int num, input string name, input int errors);
	tests_run++;
	if (errors == 0) begin
		$display("test %0d %s: pass", num, name);
	end else begin
		$display("test %0d %s: FAIL with %0d mismatches", num, name, errors);
		tests_failed++;
	end
endtask

task automatic run_tests();
	int base_errors;
	int base_black;
	@(posedge Clock);
	test_num <= 3'd1;
	idle_check <= 1'b1;
	repeat (20) @(posedge Clock);
	// Camera still off, so this pulse is not counted
	pulse_frame_start(1'b0);
	// Camera enable rises after BUF_START and one startup delay
	repeat (`STARTUP_DELAY) @(posedge Clock);
	idle_check <= 1'b0;
	report_test(1, "reset_idle", idle_errors);

	test_num <= 3'd2;
	base_errors = pixel_errors;
	pulse_frame_start(1'b1);
	send_pixels(`FIFO_DEPTH, `FIFO_DEPTH);
	pulse_frame_start(1'b1);
	wait_for(COND_SHOWN, `FIFO_DEPTH, 300000, "the first buffer of pixels on the LCD");
	if (timed_out)
		return;
	report_test(2, "first_frame", pixel_errors - base_errors);

	test_num <= 3'd4;
	base_errors = pixel_errors;
	base_black = black_shown;
	wait_for(COND_UNDERFLOW, 0, 10000, "the underflow flag");
	if (timed_out)
		return;
	wait_for(COND_BLACK, base_black + 16, 10000, "black pixels after the buffer ran empty");
	if (timed_out)
		return;
	report_test(4, "underflow", pixel_errors - base_errors);

	test_num <= 3'd5;
	base_errors = pixel_errors;
	reload <= 1'b1;
	repeat (4) @(posedge Clock);
	reload <= 1'b0;
	wait_for(COND_CLEARED, 0, 64, "both flags to clear after reload");
	if (timed_out)
		return;
	pulse_frame_start(1'b0);
	// Through RELOAD_WAIT, BUF_START and WAIT_BUF again
	repeat (2 * `STARTUP_DELAY + 16) @(posedge Clock);
	pulse_frame_start(1'b1);
	send_pixels(`FIFO_DEPTH + 6, `FIFO_DEPTH);
	wait_for(COND_OVERFLOW, 0, 1000, "the overflow flag");
	if (timed_out)
		return;
	wait_for(COND_SHOWN, 2 * `FIFO_DEPTH, 300000, "the second buffer of pixels on the LCD");
	if (timed_out)
		return;
	// Dropped pixels must not show up
	base_black = black_shown;
	wait_for(COND_BLACK, base_black + 8, 10000, "black pixels after the full buffer");
	if (timed_out)
		return;
	report_test(5, "reload_overflow", pixel_errors - base_errors);

	report_test(3, "scan_timing", timing_errors);

	test_num <= 3'd6;
	exp_frames <= frame_count_t'(frames_sent);
	frame_check <= 1'b1;
	@(posedge Clock);
	frame_check <= 1'b0;
	@(posedge Clock);
	report_test(6, "frame_count", frame_errors);
endtask

initial begin
	seed = 81;
	frames_sent = 0;
	tests_run = 0;
	tests_failed = 0;
	timed_out = 1'b0;
	Resetn = 1'b0;
	cam_valid = 1'b0;
	cam_frame_start = 1'b0;
	cam_red = '0;
	cam_green = '0;
	cam_blue = '0;
	reload = 1'b0;
	test_num = 3'd0;
	idle_check = 1'b0;
	exp_push = 1'b0;
	exp_r = '0;
	exp_g = '0;
	exp_b = '0;
	frame_check = 1'b0;
	exp_frames = '0;
	repeat (10) @(posedge Clock);
	Resetn <= 1'b1;
	run_tests();
	total_errors = pixel_errors + timing_errors + idle_errors + frame_errors;
	$display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed,
		total_errors);
	if (timed_out || tests_failed != 0 || total_errors != 0)
		$display("Errors found");
	else
		$display("No errors");
	$finish;
end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/pixel_pkg.sv
logic/control_pkg.sv
logic/camera_packer.sv
logic/frame_fifo.sv
logic/lcd_scanout.sv
logic/bring_up_sequencer.sv
logic/camera_lcd_top.sv
tb/lcd_checker.sv
tb/tb_camera_lcd.sv

// File: Makefile
# Verilator simulation of the camera to LCD video path

VERILATOR ?= verilator
TOP ?= tb_camera_lcd
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
